//--- compile.f
hdl/ita_ctrl_pkg.sv
hdl/step_sequencer.sv
hdl/tile_walker.sv
hdl/bias_padder.sv
hdl/ita_ctrl_top.sv
test/tb_ita_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
  --top-module tb_ita_ctrl -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- test/tb_ita_ctrl.sv
// ####################
// tiling controller testbench
// directed runs with beat, tile and padding checks
// ####################

`timescale 1ns/1ns

module tb_ita_ctrl import ita_ctrl_pkg::*; ();

  localparam int M          = 4;
  localparam int N          = 2;
  localparam int FIFO_DEPTH = 4;
  localparam int BEATS      = M * M / N;

  logic               clk_i, rst_ni, start_i;
  layer_e             layer_i;
  counter_t           seq_len_i, embed_len_i, proj_len_i, ff_len_i;
  logic               inp_valid_i, weight_valid_i, bias_valid_i;
  logic               oup_valid_i, oup_ready_i;
  logic               inp_ready_o, weight_ready_o, bias_ready_o;
  bias_lane_t [N-1:0] bias_i, bias_pad_o;
  step_e              step_o;
  logic               busy_o, calc_en_o, first_inner_tile_o, last_inner_tile_o;
  counter_t           tile_x_o, tile_y_o, inner_tile_o;

  int    step_beats;         // accepted beats in the current step
  int    beats_per_step [4];
  step_e last_step;
  step_e step_trace [$];

  ita_ctrl_top #(
    .M          (M),
    .N          (N),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_ita_ctrl_top (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (start_i),
    .layer_i            (layer_i),
    .seq_len_i          (seq_len_i),
    .embed_len_i        (embed_len_i),
    .proj_len_i         (proj_len_i),
    .ff_len_i           (ff_len_i),
    .inp_valid_i        (inp_valid_i),
    .inp_ready_o        (inp_ready_o),
    .weight_valid_i     (weight_valid_i),
    .weight_ready_o     (weight_ready_o),
    .bias_valid_i       (bias_valid_i),
    .bias_ready_o       (bias_ready_o),
    .bias_i             (bias_i),
    .oup_valid_i        (oup_valid_i),
    .oup_ready_i        (oup_ready_i),
    .step_o             (step_o),
    .busy_o             (busy_o),
    .calc_en_o          (calc_en_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o),
    .inner_tile_o       (inner_tile_o),
    .bias_pad_o         (bias_pad_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // fresh bias lanes every cycle
  always @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      bias_i[i] <= bias_lane_t'($urandom);
    end
  end

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  function automatic int ceil_tiles(input int len);
    return (len + M - 1) / M;
  endfunction

  function automatic int inner_len_of(input step_e st);
    return (st == StepF2) ? int'(ff_len_i) : int'(embed_len_i);
  endfunction

  function automatic int col_len_of(input step_e st);
    case (st)
      StepMatMul: return int'(proj_len_i);
      StepF1:     return int'(ff_len_i);
      default:    return int'(embed_len_i); // F2 maps back to embed
    endcase
  endfunction

  function automatic int expected_beats(input step_e st);
    return ceil_tiles(seq_len_i) * ceil_tiles(col_len_of(st))
           * ceil_tiles(inner_len_of(st)) * BEATS;
  endfunction

  // tile position, inner tile flags and padded lanes from the own beat count
  task automatic check_beat();
    int inner_t, col_t, b, tile, inner_idx, row, col;
    bias_lane_t exp_lane;
    inner_t   = ceil_tiles(inner_len_of(step_o));
    col_t     = ceil_tiles(col_len_of(step_o));
    b         = step_beats % BEATS;
    tile      = step_beats / (BEATS * inner_t);
    inner_idx = (step_beats / BEATS) % inner_t;
    check(inner_tile_o, inner_idx, "inner tile index");
    check(first_inner_tile_o, inner_idx == 0, "first_inner_tile_o");
    check(last_inner_tile_o, inner_idx == inner_t - 1, "last_inner_tile_o");
    check(tile_x_o, tile % col_t, "tile_x_o");
    check(tile_y_o, tile / col_t, "tile_y_o");
    row = int'(tile_y_o) * M + b % M;
    for (int i = 0; i < N; i++) begin
      col = int'(tile_x_o) * M + (b / M) * N + i;
      if (row >= int'(seq_len_i) || col >= col_len_of(step_o)) begin
        exp_lane = '0;
      end else begin
        exp_lane = bias_i[i];
      end
      check(bias_pad_o[i], exp_lane, $sformatf("bias_pad_o lane %0d", i));
    end
  endtask

  task automatic observe_cycle();
    @(negedge clk_i);
    if (step_o != last_step) begin
      last_step  = step_o;
      step_beats = 0;
      if (step_o != StepIdle) step_trace.push_back(step_o);
    end
    if (calc_en_o) begin
      check_beat();
      step_beats++;
      beats_per_step[int'(step_o)]++;
    end
  endtask

  task automatic start_layer(input layer_e layer, input int s, e, p, f);
    @(posedge clk_i);
    layer_i     <= layer;
    seq_len_i   <= counter_t'(s);
    embed_len_i <= counter_t'(e);
    proj_len_i  <= counter_t'(p);
    ff_len_i    <= counter_t'(f);
    start_i     <= 1'b1;
    step_trace.delete();
    beats_per_step = '{default: 0};
    step_beats     = 0;
    last_step      = StepIdle;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic finish_layer(input int limit);
    int n;
    n = 0;
    do begin
      observe_cycle();
      n++;
      if (n > limit) begin
        $display("timeout: busy_o still high after %0d cycles", limit);
        abort_run();
      end
    end while (busy_o);
  endtask

  task automatic check_steps(input layer_e layer);
    check(step_o, StepIdle, "step_o after the run");
    if (layer == LayerLinear) begin
      check(step_trace.size(), 1, "linear step count");
      check(step_trace[0], StepMatMul, "linear step");
      check(beats_per_step[StepMatMul], expected_beats(StepMatMul), "matmul beats");
    end else begin
      check(step_trace.size(), 2, "feedforward step count");
      check(step_trace[0], StepF1, "first feedforward step");
      check(step_trace[1], StepF2, "second feedforward step");
      check(beats_per_step[StepF1], expected_beats(StepF1), "f1 beats");
      check(beats_per_step[StepF2], expected_beats(StepF2), "f2 beats");
    end
  endtask

  task automatic check_quiet(input string msg);
    check(inp_ready_o, 1'b0, {msg, " inp_ready_o"});
    check(weight_ready_o, 1'b0, {msg, " weight_ready_o"});
    check(bias_ready_o, 1'b0, {msg, " bias_ready_o"});
    check(calc_en_o, 1'b0, {msg, " calc_en_o"});
    check(busy_o, 1'b0, {msg, " busy_o"});
    check(step_o, StepIdle, {msg, " step_o"});
  endtask

  task automatic check_join();
    observe_cycle();
    check(calc_en_o, 1'b0, "calc_en_o without bias");
    check(inp_ready_o, weight_valid_i, "inp_ready_o follows weight_valid_i");
    check(bias_ready_o, weight_valid_i, "bias_ready_o follows weight_valid_i");
    check(weight_ready_o, inp_valid_i, "weight_ready_o follows inp_valid_i");
  endtask

  task automatic test_reset();
    for (int c = 0; c < 10; c++) begin
      @(negedge clk_i);
      check_quiet("during reset");
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_quiet("after reset");
    end
  endtask

  task automatic test_back_pressure();
    int n;
    @(posedge clk_i);
    oup_ready_i <= 1'b0;
    start_layer(LayerLinear, 8, 8, 8, 0);
    n = 0;
    do begin
      observe_cycle();
      n++;
      if (n > 200) begin
        $display("timeout: readies never dropped with the output FIFO full");
        abort_run();
      end
    end while (inp_ready_o);
    // first inner tile is free, then one beat per credit
    check(beats_per_step[StepMatMul], BEATS + FIFO_DEPTH, "beats before stall");
    repeat (20) begin
      observe_cycle();
      check(inp_ready_o | weight_ready_o | bias_ready_o | calc_en_o, 1'b0, "stalled join");
    end
    @(posedge clk_i);
    oup_ready_i <= 1'b1;
    observe_cycle();
    @(posedge clk_i);
    oup_ready_i <= 1'b0;
    repeat (10) observe_cycle();
    check(beats_per_step[StepMatMul], BEATS + FIFO_DEPTH + 1, "beats after one credit");
    check(inp_ready_o, 1'b0, "inp_ready_o stalled again");
    @(posedge clk_i);
    oup_ready_i <= 1'b1;
    finish_layer(2000);
    check_steps(LayerLinear);
  endtask

  task automatic test_join();
    @(posedge clk_i);
    bias_valid_i <= 1'b0;
    start_layer(LayerLinear, 4, 4, 4, 0);
    repeat (5) check_join();
    @(posedge clk_i);
    weight_valid_i <= 1'b0;
    repeat (5) check_join();
    check(beats_per_step[StepMatMul], 0, "beats without bias");
    @(posedge clk_i);
    weight_valid_i <= 1'b1;
    bias_valid_i   <= 1'b1;
    finish_layer(2000);
    check_steps(LayerLinear);
  endtask

  initial begin
    void'($urandom(92137));
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    layer_i        = LayerLinear;
    seq_len_i      = '0;
    embed_len_i    = '0;
    proj_len_i     = '0;
    ff_len_i       = '0;
    inp_valid_i    = 1'b1;
    weight_valid_i = 1'b1;
    bias_valid_i   = 1'b1;
    oup_valid_i    = 1'b1;
    oup_ready_i    = 1'b1; // drained every cycle
    bias_i         = '0;
    step_beats     = 0;
    last_step      = StepIdle;

    test_reset();
    start_layer(LayerLinear, 8, 8, 8, 0);
    finish_layer(2000);
    check_steps(LayerLinear);
    start_layer(LayerLinear, 6, 8, 5, 0); // edge padding
    finish_layer(2000);
    check_steps(LayerLinear);
    start_layer(LayerFeedforward, 5, 6, 0, 9);
    finish_layer(4000);
    check_steps(LayerFeedforward);
    test_back_pressure();
    test_join();

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- hdl/ita_ctrl_top.sv
// ####################
// tiling controller top
// step sequencing, tile walking and bias padding
// ####################

`timescale 1ns/1ns

module ita_ctrl_top import ita_ctrl_pkg::*; #(
  parameter int unsigned M          = 8,
  parameter int unsigned N          = 4,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  layer_e             layer_i,
  input  counter_t           seq_len_i,
  input  counter_t           embed_len_i,
  input  counter_t           proj_len_i,
  input  counter_t           ff_len_i,
  input  logic               inp_valid_i,
  output logic               inp_ready_o,
  input  logic               weight_valid_i,
  output logic               weight_ready_o,
  input  logic               bias_valid_i,
  output logic               bias_ready_o,
  input  bias_lane_t [N-1:0] bias_i,
  input  logic               oup_valid_i,
  input  logic               oup_ready_i,
  output step_e              step_o,
  output logic               busy_o,
  output logic               calc_en_o,
  output logic               first_inner_tile_o,
  output logic               last_inner_tile_o,
  output counter_t           tile_x_o,
  output counter_t           tile_y_o,
  output counter_t           inner_tile_o,
  output bias_lane_t [N-1:0] bias_pad_o
);

  counter_t inner_tiles, col_tiles, row_tiles;
  counter_t row_len, col_len;
  counter_t beat;
  logic     step_done;

  step_sequencer #(
    .M (M)
  ) i_step_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .layer_i       (layer_i),
    .seq_len_i     (seq_len_i),
    .embed_len_i   (embed_len_i),
    .proj_len_i    (proj_len_i),
    .ff_len_i      (ff_len_i),
    .step_done_i   (step_done),
    .step_o        (step_o),
    .active_o      (busy_o), // busy while any step runs
    .inner_tiles_o (inner_tiles),
    .col_tiles_o   (col_tiles),
    .row_tiles_o   (row_tiles),
    .row_len_o     (row_len),
    .col_len_o     (col_len)
  );

  tile_walker #(
    .M          (M),
    .N          (N),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_tile_walker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .active_i           (busy_o),
    .inner_tiles_i      (inner_tiles),
    .col_tiles_i        (col_tiles),
    .row_tiles_i        (row_tiles),
    .inp_valid_i        (inp_valid_i),
    .weight_valid_i     (weight_valid_i),
    .bias_valid_i       (bias_valid_i),
    .oup_valid_i        (oup_valid_i),
    .oup_ready_i        (oup_ready_i),
    .inp_ready_o        (inp_ready_o),
    .weight_ready_o     (weight_ready_o),
    .bias_ready_o       (bias_ready_o),
    .calc_en_o          (calc_en_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o),
    .step_done_o        (step_done),
    .beat_o             (beat),
    .inner_tile_o       (inner_tile_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o)
  );

  bias_padder #(
    .M (M),
    .N (N)
  ) i_bias_padder (
    .beat_i     (beat),
    .tile_x_i   (tile_x_o),
    .tile_y_i   (tile_y_o),
    .row_len_i  (row_len),
    .col_len_i  (col_len),
    .bias_i     (bias_i),
    .bias_pad_o (bias_pad_o)
  );

endmodule

//--- hdl/bias_padder.sv
// ####################
// bias padder
// zeroes bias lanes past the matrix edges
// ####################

`timescale 1ns/1ns

module bias_padder import ita_ctrl_pkg::*; #(
  parameter int unsigned M = 8,
  parameter int unsigned N = 4
) (
  input  counter_t           beat_i,
  input  counter_t           tile_x_i,
  input  counter_t           tile_y_i,
  input  counter_t           row_len_i,
  input  counter_t           col_len_i,
  input  bias_lane_t [N-1:0] bias_i,
  output bias_lane_t [N-1:0] bias_pad_o
);

  logic [31:0] row;
  logic [31:0] col_base;
  logic        row_out;

  // beats run down a column group of N lanes, M rows each
  assign row      = 32'(tile_y_i) * M + 32'(beat_i) % M;
  assign col_base = 32'(tile_x_i) * M + (32'(beat_i) / M) * N;
  assign row_out  = (row >= 32'(row_len_i));

  always_comb begin
    for (int i = 0; i < N; i++) begin
      if (row_out || (col_base + 32'(i) >= 32'(col_len_i))) begin
        bias_pad_o[i] = '0;
      end else begin
        bias_pad_o[i] = bias_i[i];
      end
    end
  end

endmodule

//--- hdl/tile_walker.sv
// ####################
// tile walker
// stream join, beat and tile counters, output credits
// ####################

`timescale 1ns/1ns

module tile_walker import ita_ctrl_pkg::*; #(
  parameter int unsigned M          = 8,
  parameter int unsigned N          = 4,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     active_i,
  input  counter_t inner_tiles_i,
  input  counter_t col_tiles_i,
  input  counter_t row_tiles_i,
  input  logic     inp_valid_i,
  input  logic     weight_valid_i,
  input  logic     bias_valid_i,
  input  logic     oup_valid_i,
  input  logic     oup_ready_i,
  output logic     inp_ready_o,
  output logic     weight_ready_o,
  output logic     bias_ready_o,
  output logic     calc_en_o,
  output logic     first_inner_tile_o,
  output logic     last_inner_tile_o,
  output logic     step_done_o,
  output counter_t beat_o,
  output counter_t inner_tile_o,
  output counter_t tile_x_o,
  output counter_t tile_y_o
);

  localparam int unsigned BEATS    = M * M / N;
  localparam int unsigned CREDIT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(FIFO_DEPTH);

  counter_t beat_q, inner_q, tile_x_q, tile_y_q;
  logic [CREDIT_W-1:0] credits_q;
  logic open, last_beat, last_x, last_y;
  logic credit_add, credit_sub;

  assign open = active_i && (credits_q < CREDIT_MAX);

  // three-way join, each ready follows the other stream
  assign inp_ready_o    = open & weight_valid_i;
  assign weight_ready_o = open & inp_valid_i;
  assign bias_ready_o   = open & weight_valid_i;
  assign calc_en_o      = open & inp_valid_i & weight_valid_i & bias_valid_i;

  assign last_beat          = (beat_q == counter_t'(BEATS - 1));
  assign first_inner_tile_o = (inner_q == '0);
  assign last_inner_tile_o  = (inner_q == inner_tiles_i - 16'd1);
  assign last_x             = (tile_x_q == col_tiles_i - 16'd1);
  assign last_y             = (tile_y_q == row_tiles_i - 16'd1);
  assign step_done_o = calc_en_o & last_beat & last_inner_tile_o & last_x & last_y;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end else if (!active_i) begin
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end else if (calc_en_o) begin
      if (!last_beat) begin
        beat_q <= beat_q + 16'd1;
      end else begin
        beat_q <= '0;
        if (!last_inner_tile_o) begin
          inner_q <= inner_q + 16'd1;
        end else begin
          inner_q <= '0;
          // x first, then wrap into y
          if (!last_x) begin
            tile_x_q <= tile_x_q + 16'd1;
          end else begin
            tile_x_q <= '0;
            if (last_y) begin
              tile_y_q <= '0; // step complete
            end else begin
              tile_y_q <= tile_y_q + 16'd1;
            end
          end
        end
      end
    end
  end

  // one credit per result beat headed for the output fifo
  assign credit_add = calc_en_o & last_inner_tile_o;
  assign credit_sub = oup_valid_i & oup_ready_i & (credits_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= '0;
    end else if (credit_add && !credit_sub) begin
      credits_q <= credits_q + 1'b1;
    end else if (credit_sub && !credit_add) begin
      credits_q <= credits_q - 1'b1;
    end
  end

  assign beat_o       = beat_q;
  assign inner_tile_o = inner_q;
  assign tile_x_o     = tile_x_q;
  assign tile_y_o     = tile_y_q;

endmodule

//--- hdl/step_sequencer.sv
// ####################
// step sequencer
// layer decode into steps, per-step tile counts and bounds
// ####################

`timescale 1ns/1ns

module step_sequencer import ita_ctrl_pkg::*; #(
  parameter int unsigned M = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  layer_e   layer_i,
  input  counter_t seq_len_i,
  input  counter_t embed_len_i,
  input  counter_t proj_len_i,
  input  counter_t ff_len_i,
  input  logic     step_done_i,
  output step_e    step_o,
  output logic     active_o,
  output counter_t inner_tiles_o,
  output counter_t col_tiles_o,
  output counter_t row_tiles_o,
  output counter_t row_len_o,
  output counter_t col_len_o
);

  step_e    step_d, step_q;
  counter_t inner_len;
  counter_t col_len;

  // ceil(len / M), one extra bit so len near max does not wrap
  function automatic counter_t ceil_tiles(input counter_t len);
    logic [16:0] sum;
    sum = {1'b0, len} + 17'(M - 1);
    return counter_t'(sum / M);
  endfunction

  always_comb begin
    step_d = step_q;
    case (step_q)
      StepIdle: begin
        if (start_i) begin
          step_d = (layer_i == LayerFeedforward) ? StepF1 : StepMatMul;
        end
      end
      StepMatMul: if (step_done_i) step_d = StepIdle;
      StepF1:     if (step_done_i) step_d = StepF2;
      StepF2:     if (step_done_i) step_d = StepIdle;
      default:    step_d = StepIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= StepIdle;
    end else begin
      step_q <= step_d;
    end
  end

  // inner and column dimension per step
  always_comb begin
    inner_len = '0;
    col_len   = '0;
    case (step_q)
      StepMatMul: begin
        inner_len = embed_len_i;
        col_len   = proj_len_i;
      end
      StepF1: begin
        inner_len = embed_len_i;
        col_len   = ff_len_i;
      end
      StepF2: begin
        inner_len = ff_len_i;
        col_len   = embed_len_i; // back to embed width
      end
      default: ;
    endcase
  end

  assign step_o        = step_q;
  assign active_o      = (step_q != StepIdle);
  assign row_len_o     = seq_len_i; // every step runs over the sequence
  assign col_len_o     = col_len;
  assign row_tiles_o   = ceil_tiles(seq_len_i);
  assign col_tiles_o   = ceil_tiles(col_len);
  assign inner_tiles_o = ceil_tiles(inner_len);

endmodule

//--- hdl/ita_ctrl_pkg.sv
// ####################
// tiling controller types
// counters, bias lanes, layer and step encodings
// ####################

package ita_ctrl_pkg;

  // dimensions, tile and beat indices
  typedef logic [15:0] counter_t;

  // one bias value per lane
  typedef logic signed [23:0] bias_lane_t;

  // layer kinds the decoder understands
  typedef enum logic [0:0] {
    LayerLinear      = 1'b0,
    LayerFeedforward = 1'b1
  } layer_e;

  // matrix step currently being walked
  typedef enum logic [1:0] {
    StepIdle   = 2'd0,
    StepMatMul = 2'd1, // linear layer
    StepF1     = 2'd2, // feedforward, first projection
    StepF2     = 2'd3  // feedforward, back to embed
  } step_e;

endpackage
